/* verilog/exc_pkg.sv */
package exc_pkg;

    // Cause.ExcCode values.
    typedef enum logic [4:0] {
        INT  = 5'd0,
        MOD  = 5'd1,
        TLBL = 5'd2,
        TLBS = 5'd3,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12,
        NONE = 5'd31
    } exc_code_e;

    // Exception flags of the committing instruction.
    typedef struct packed {
        logic eret;
        logic syscall;
        logic brk;
        logic inst_adel;
        logic data_adel;
        logic data_ades;
        logic overflow;
        logic ri;
        logic i_refill;
        logic i_invalid;
        logic d_refill_l;
        logic d_invalid_l;
        logic d_refill_s;
        logic d_invalid_s;
        logic modify;
    } exc_flags_t;

    localparam logic [4:0] CP0_BADVADDR = 5'd8;
    localparam logic [4:0] CP0_ENTRYHI  = 5'd10;
    localparam logic [4:0] CP0_STATUS   = 5'd12;
    localparam logic [4:0] CP0_CAUSE    = 5'd13;
    localparam logic [4:0] CP0_EPC      = 5'd14;

endpackage

/* verilog/cp0_write_if.sv */
`timescale 1ns/1ps

interface cp0_write_if import exc_pkg::*; ();

    logic        update;
    exc_code_e   exccode;
    logic        bd;
    logic [31:0] epc;
    logic        badvaddr_en;
    logic [31:0] badvaddr;
    logic        entryhi_en;
    logic [18:0] entryhi_vpn2;
    logic        clr_exl;

    // Controller side drives the update for one cycle.
    modport ctrl (
        output update, exccode, bd, epc, badvaddr_en, badvaddr,
               entryhi_en, entryhi_vpn2, clr_exl
    );

    modport cp0 (
        input update, exccode, bd, epc, badvaddr_en, badvaddr,
              entryhi_en, entryhi_vpn2, clr_exl
    );

endinterface

/* verilog/commit_latch.sv */
`timescale 1ns/1ps

module commit_latch import exc_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,

    input  logic        in_valid,
    input  logic        in_refetch,
    input  logic        in_delay_slot,
    input  logic [31:0] in_pc,
    input  logic [31:0] in_badvaddr,
    input  exc_flags_t  in_flags,

    output logic        q_valid,
    output logic        q_refetch,
    output logic        q_delay_slot,
    output logic [31:0] q_pc,
    output logic [31:0] q_badvaddr,
    output exc_flags_t  q_flags
);

    // The valid bit drops whenever the controller flushes.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_valid <= 1'b0;
        end else begin
            q_valid <= in_valid & ~flush;
        end
    end

    // Payload loads on every cycle without a flush.
    always_ff @(posedge clk) begin
        if (!flush) begin
            q_refetch    <= in_refetch;
            q_delay_slot <= in_delay_slot;
            q_pc         <= in_pc;
            q_badvaddr   <= in_badvaddr;
            q_flags      <= in_flags;
        end
    end

endmodule

/* verilog/exception_ctrl.sv */
`timescale 1ns/1ps

module exception_ctrl import exc_pkg::*; #(
    parameter logic [31:0] EXC_VECTOR    = 32'hbfc0_0380,
    parameter logic [31:0] REFILL_VECTOR = 32'hbfc0_0200
) (
    input  logic         q_valid,
    input  logic         q_refetch,
    input  logic         q_delay_slot,
    input  logic         int_pending,
    input  logic [31:0]  q_pc,
    input  logic [31:0]  q_badvaddr,
    input  logic [31:0]  epc,
    input  exc_flags_t   q_flags,

    output logic         redirect_valid,
    output logic         flush,
    output logic [31:0]  redirect_pc,
    cp0_write_if.ctrl    wr
);

    logic [$bits(exc_flags_t)-1:0] flag_bits;
    logic                          any_exc;
    logic                          exc_taken;

    exc_code_e   code;
    logic        is_refill;
    logic        is_eret;
    logic        rec_badvaddr;
    logic        rec_entryhi;
    logic [31:0] fault_addr;

    assign flag_bits = q_flags;
    assign any_exc   = int_pending | (|flag_bits);
    assign exc_taken = q_valid & ~q_refetch & any_exc;

    assign redirect_valid = q_valid & (q_refetch | any_exc);
    assign flush          = redirect_valid;

    // ==================================================
    // Fixed priority selection
    // ==================================================
    always_comb begin
        code         = NONE;
        is_refill    = 1'b0;
        is_eret      = 1'b0;
        rec_badvaddr = 1'b0;
        rec_entryhi  = 1'b0;
        fault_addr   = q_pc;
        if (int_pending) begin
            code = INT;
        end else if (q_flags.i_refill || q_flags.i_invalid) begin
            code         = TLBL;
            is_refill    = q_flags.i_refill;
            rec_badvaddr = 1'b1;
            rec_entryhi  = 1'b1;
        end else if (q_flags.inst_adel) begin
            code         = ADEL;
            rec_badvaddr = 1'b1;
        end else if (q_flags.ri) begin
            code = RI;
        end else if (q_flags.overflow) begin
            code = OV;
        end else if (q_flags.syscall) begin
            code = SYS;
        end else if (q_flags.brk) begin
            code = BP;
        end else if (q_flags.eret) begin
            is_eret = 1'b1;
        end else begin
            // Remaining kinds are all data side faults.
            fault_addr   = q_badvaddr;
            rec_badvaddr = 1'b1;
            if (q_flags.d_refill_l || q_flags.d_invalid_l) begin
                code        = TLBL;
                is_refill   = q_flags.d_refill_l;
                rec_entryhi = 1'b1;
            end else if (q_flags.d_refill_s || q_flags.d_invalid_s) begin
                code        = TLBS;
                is_refill   = q_flags.d_refill_s;
                rec_entryhi = 1'b1;
            end else if (q_flags.data_adel) begin
                code = ADEL;
            end else if (q_flags.data_ades) begin
                code = ADES;
            end else if (q_flags.modify) begin
                code        = MOD;
                rec_entryhi = 1'b1;
            end else begin
                rec_badvaddr = 1'b0;
            end
        end
    end

    // Refetch wins over any exception.
    always_comb begin
        if (q_refetch) begin
            redirect_pc = q_pc;
        end else if (is_eret) begin
            redirect_pc = epc;
        end else if (is_refill) begin
            redirect_pc = REFILL_VECTOR;
        end else begin
            redirect_pc = EXC_VECTOR;
        end
    end

    // ==================================================
    // CP0 update
    // ==================================================
    assign wr.update       = exc_taken & ~is_eret;
    assign wr.clr_exl      = exc_taken & is_eret;
    assign wr.exccode      = code;
    assign wr.bd           = q_delay_slot;
    assign wr.epc          = q_delay_slot ? q_pc - 32'd4 : q_pc;
    assign wr.badvaddr_en  = exc_taken & rec_badvaddr;
    assign wr.badvaddr     = fault_addr;
    assign wr.entryhi_en   = exc_taken & rec_entryhi;
    assign wr.entryhi_vpn2 = fault_addr[31:13];

endmodule

/* verilog/cp0_regs.sv */
`timescale 1ns/1ps

module cp0_regs import exc_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [5:0]  hw_int,

    input  logic        cp0_wen,
    input  logic [4:0]  cp0_addr,
    input  logic [31:0] cp0_wdata,
    output logic [31:0] cp0_rdata,

    output logic [31:0] epc,
    output logic        int_pending,
    cp0_write_if.cp0    wr
);

    logic        status_ie;
    logic        status_exl;
    logic [7:0]  status_im;
    logic        cause_bd;
    logic [7:0]  cause_ip;
    exc_code_e   cause_exccode;
    logic [31:0] epc_q;
    logic [31:0] badvaddr_q;
    logic [18:0] entryhi_vpn2;
    logic [7:0]  entryhi_asid;

    // ==================================================
    // Status and Cause
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_ie     <= 1'b0;
            status_exl    <= 1'b0;
            status_im     <= 8'h00;
            cause_bd      <= 1'b0;
            cause_ip      <= 8'h00;
            cause_exccode <= INT;
        end else begin
            // Hardware lines sampled every cycle.
            cause_ip[7:2] <= hw_int;
            if (cp0_wen && cp0_addr == CP0_STATUS) begin
                status_ie  <= cp0_wdata[0];
                status_exl <= cp0_wdata[1];
                status_im  <= cp0_wdata[15:8];
            end
            if (cp0_wen && cp0_addr == CP0_CAUSE) begin
                cause_ip[1:0] <= cp0_wdata[9:8];
            end
            // Exception entry and return override software.
            if (wr.update) begin
                status_exl    <= 1'b1;
                cause_bd      <= wr.bd;
                cause_exccode <= wr.exccode;
            end else if (wr.clr_exl) begin
                status_exl <= 1'b0;
            end
        end
    end

    // ==================================================
    // EPC, BadVAddr, EntryHi
    // ==================================================
    always_ff @(posedge clk) begin
        if (wr.update) begin
            epc_q <= wr.epc;
        end else if (cp0_wen && cp0_addr == CP0_EPC) begin
            epc_q <= cp0_wdata;
        end
        if (wr.badvaddr_en) begin
            badvaddr_q <= wr.badvaddr;
        end
        if (wr.entryhi_en) begin
            entryhi_vpn2 <= wr.entryhi_vpn2;
        end else if (cp0_wen && cp0_addr == CP0_ENTRYHI) begin
            entryhi_vpn2 <= cp0_wdata[31:13];
        end
        // ASID is kept across faults.
        if (cp0_wen && cp0_addr == CP0_ENTRYHI) begin
            entryhi_asid <= cp0_wdata[7:0];
        end
    end

    assign epc         = epc_q;
    assign int_pending = status_ie & ~status_exl & (|(cause_ip & status_im));

    always_comb begin
        case (cp0_addr)
            CP0_STATUS:   cp0_rdata = {16'h0, status_im, 6'h0, status_exl, status_ie};
            CP0_CAUSE:    cp0_rdata = {cause_bd, 15'h0, cause_ip, 1'b0, cause_exccode, 2'b00};
            CP0_EPC:      cp0_rdata = epc_q;
            CP0_BADVADDR: cp0_rdata = badvaddr_q;
            CP0_ENTRYHI:  cp0_rdata = {entryhi_vpn2, 5'h00, entryhi_asid};
            default:      cp0_rdata = 32'h0;
        endcase
    end

endmodule

/* verilog/exception_unit.sv */
`timescale 1ns/1ps

module exception_unit import exc_pkg::*; #(
    parameter logic [31:0] EXC_VECTOR    = 32'hbfc0_0380,
    parameter logic [31:0] REFILL_VECTOR = 32'hbfc0_0200
) (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        in_valid,
    input  logic        in_refetch,
    input  logic        in_delay_slot,
    input  logic [31:0] in_pc,
    input  logic [31:0] in_badvaddr,
    input  exc_flags_t  in_flags,

    input  logic [5:0]  hw_int,
    input  logic        cp0_wen,
    input  logic [4:0]  cp0_addr,
    input  logic [31:0] cp0_wdata,
    output logic [31:0] cp0_rdata,

    output logic        redirect_valid,
    output logic [31:0] redirect_pc,
    output logic        flush
);

    logic        q_valid;
    logic        q_refetch;
    logic        q_delay_slot;
    logic [31:0] q_pc;
    logic [31:0] q_badvaddr;
    exc_flags_t  q_flags;
    logic [31:0] epc;
    logic        int_pending;

    cp0_write_if cp0_wr ();

    commit_latch i_commit_latch (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush         (flush),
        .in_valid      (in_valid),
        .in_refetch    (in_refetch),
        .in_delay_slot (in_delay_slot),
        .in_pc         (in_pc),
        .in_badvaddr   (in_badvaddr),
        .in_flags      (in_flags),
        .q_valid       (q_valid),
        .q_refetch     (q_refetch),
        .q_delay_slot  (q_delay_slot),
        .q_pc          (q_pc),
        .q_badvaddr    (q_badvaddr),
        .q_flags       (q_flags)
    );

    exception_ctrl #(
        .EXC_VECTOR    (EXC_VECTOR),
        .REFILL_VECTOR (REFILL_VECTOR)
    ) i_exception_ctrl (
        .q_valid        (q_valid),
        .q_refetch      (q_refetch),
        .q_delay_slot   (q_delay_slot),
        .int_pending    (int_pending),
        .q_pc           (q_pc),
        .q_badvaddr     (q_badvaddr),
        .epc            (epc),
        .q_flags        (q_flags),
        .redirect_valid (redirect_valid),
        .flush          (flush),
        .redirect_pc    (redirect_pc),
        .wr             (cp0_wr.ctrl)
    );

    cp0_regs i_cp0_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .hw_int      (hw_int),
        .cp0_wen     (cp0_wen),
        .cp0_addr    (cp0_addr),
        .cp0_wdata   (cp0_wdata),
        .cp0_rdata   (cp0_rdata),
        .epc         (epc),
        .int_pending (int_pending),
        .wr          (cp0_wr.cp0)
    );

endmodule

/* bench/exception_unit_properties.sv */
`timescale 1ns/1ps

module exception_unit_properties import exc_pkg::*; #(
    parameter logic [31:0] EXC_VECTOR    = 32'hbfc0_0380,
    parameter logic [31:0] REFILL_VECTOR = 32'hbfc0_0200
) (
    input logic        clk,
    input logic        rst_n,
    input logic        in_valid,
    input logic        in_refetch,
    input exc_flags_t  in_flags,
    input logic        q_refetch,
    input exc_flags_t  q_flags,
    input logic        int_pending,
    input logic        redirect_valid,
    input logic        flush,
    input logic [31:0] redirect_pc
);

    int unsigned fail_count = 0;

    logic lone_data_refill;
    logic lone_plain_exc;

    assign lone_data_refill = $onehot(q_flags) && (q_flags.d_refill_l || q_flags.d_refill_s);
    assign lone_plain_exc   = $onehot(q_flags) && !q_flags.eret && !q_flags.i_refill
                              && !q_flags.d_refill_l && !q_flags.d_refill_s;

    // ==================================================
    // Reset and redirect timing
    // ==================================================
    assert property (@(posedge clk) !rst_n |-> (!redirect_valid && !flush))
        else begin
            $error("redirect_valid or flush active during reset");
            fail_count++;
        end

    // Accepted refetch or flagged instruction redirects and flushes one cycle later.
    assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && !flush && (in_refetch || (|in_flags))) |=> (redirect_valid && flush))
        else begin
            $error("no redirect or flush one cycle after an accepted flagged instruction");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        (redirect_valid || flush) |-> $past(in_valid && !flush))
        else begin
            $error("redirect or flush without an instruction accepted one cycle earlier");
            fail_count++;
        end

    // ==================================================
    // Vector choice
    // ==================================================
    assert property (@(posedge clk) disable iff (!rst_n)
        (redirect_valid && !q_refetch && !int_pending && (q_flags.i_refill || lone_data_refill))
        |-> redirect_pc == REFILL_VECTOR)
        else begin
            $error("refill exception did not use the refill vector");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        (redirect_valid && !q_refetch && (int_pending || lone_plain_exc))
        |-> redirect_pc == EXC_VECTOR)
        else begin
            $error("general exception did not use the exception vector");
            fail_count++;
        end

endmodule

bind exception_unit exception_unit_properties #(
    .EXC_VECTOR    (EXC_VECTOR),
    .REFILL_VECTOR (REFILL_VECTOR)
) i_properties (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .in_refetch     (in_refetch),
    .in_flags       (in_flags),
    .q_refetch      (q_refetch),
    .q_flags        (q_flags),
    .int_pending    (int_pending),
    .redirect_valid (redirect_valid),
    .flush          (flush),
    .redirect_pc    (redirect_pc)
);

/* bench/tb_exception_unit.sv */
`timescale 1ns/1ps

module tb_exception_unit import exc_pkg::*; ();

    localparam int          CLK_PERIOD      = 20;
    localparam int          NUM_TESTS       = 7;
    localparam int          MAX_TEST_CYCLES = 400;
    localparam logic [31:0] EXC_VECTOR      = 32'hbfc0_0380;
    localparam logic [31:0] REFILL_VECTOR   = 32'hbfc0_0200;

    // Each priority rank holds {exccode, address source, tlb, refill}.
    // Address source is 0 for none, 1 for pc and 2 for the fault address.
    localparam logic [8:0] RANK_INFO [15] = '{
        {TLBL, 2'd1, 1'b1, 1'b1},
        {TLBL, 2'd1, 1'b1, 1'b0},
        {ADEL, 2'd1, 1'b0, 1'b0},
        {RI,   2'd0, 1'b0, 1'b0},
        {OV,   2'd0, 1'b0, 1'b0},
        {SYS,  2'd0, 1'b0, 1'b0},
        {BP,   2'd0, 1'b0, 1'b0},
        {NONE, 2'd0, 1'b0, 1'b0},
        {TLBL, 2'd2, 1'b1, 1'b1},
        {TLBL, 2'd2, 1'b1, 1'b0},
        {TLBS, 2'd2, 1'b1, 1'b1},
        {TLBS, 2'd2, 1'b1, 1'b0},
        {ADEL, 2'd2, 1'b0, 1'b0},
        {ADES, 2'd2, 1'b0, 1'b0},
        {MOD,  2'd2, 1'b1, 1'b0}
    };

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_refetch;
    logic        in_delay_slot;
    logic [31:0] in_pc;
    logic [31:0] in_badvaddr;
    exc_flags_t  in_flags;
    logic [5:0]  hw_int;
    logic        cp0_wen;
    logic [4:0]  cp0_addr;
    logic [31:0] cp0_wdata;
    logic [31:0] cp0_rdata;
    logic        redirect_valid;
    logic [31:0] redirect_pc;
    logic        flush;

    // Register model.
    logic        m_ie;
    logic        m_exl;
    logic [7:0]  m_im;
    logic [7:0]  m_ip;
    logic        m_bd;
    logic [4:0]  m_code;
    logic [31:0] m_epc;
    logic [31:0] m_badvaddr;
    logic        m_bv_known;
    logic [18:0] m_vpn2;
    logic [7:0]  m_asid;

    int     test_errors;
    int     total_errors;
    int     tests_run;
    int     tests_failed;
    integer seed = 97;

    exception_unit #(
        .EXC_VECTOR    (EXC_VECTOR),
        .REFILL_VECTOR (REFILL_VECTOR)
    ) i_exception_unit (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_refetch     (in_refetch),
        .in_delay_slot  (in_delay_slot),
        .in_pc          (in_pc),
        .in_badvaddr    (in_badvaddr),
        .in_flags       (in_flags),
        .hw_int         (hw_int),
        .cp0_wen        (cp0_wen),
        .cp0_addr       (cp0_addr),
        .cp0_wdata      (cp0_wdata),
        .cp0_rdata      (cp0_rdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .flush          (flush)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ==================================================
    // Helpers
    // ==================================================
    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("[ERROR] t=%0t %s: expected 0x%08h, got 0x%08h", $time, name, exp, got);
            test_errors++;
        end
    endtask

    function automatic exc_flags_t rank_mask(input int rank);
        exc_flags_t f;
        f = '0;
        case (rank)
            0:       f.i_refill    = 1'b1;
            1:       f.i_invalid   = 1'b1;
            2:       f.inst_adel   = 1'b1;
            3:       f.ri          = 1'b1;
            4:       f.overflow    = 1'b1;
            5:       f.syscall     = 1'b1;
            6:       f.brk         = 1'b1;
            7:       f.eret        = 1'b1;
            8:       f.d_refill_l  = 1'b1;
            9:       f.d_invalid_l = 1'b1;
            10:      f.d_refill_s  = 1'b1;
            11:      f.d_invalid_s = 1'b1;
            12:      f.data_adel   = 1'b1;
            13:      f.data_ades   = 1'b1;
            14:      f.modify      = 1'b1;
            default: f = '0;
        endcase
        return f;
    endfunction

    task automatic read_cp0(input logic [4:0] addr, output logic [31:0] data);
        @(posedge clk);
        cp0_addr <= addr;
        @(negedge clk);
        data = cp0_rdata;
    endtask

    task automatic write_cp0(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        cp0_wen   <= 1'b1;
        cp0_addr  <= addr;
        cp0_wdata <= data;
        @(posedge clk);
        cp0_wen <= 1'b0;
        if (addr == CP0_STATUS) begin
            m_ie  = data[0];
            m_exl = data[1];
            m_im  = data[15:8];
        end else if (addr == CP0_EPC) begin
            m_epc = data;
        end else if (addr == CP0_ENTRYHI) begin
            m_vpn2 = data[31:13];
            m_asid = data[7:0];
        end
    endtask

    task automatic check_regs();
        logic [31:0] data;
        read_cp0(CP0_STATUS, data);
        check("status", {16'h0, m_im, 6'h0, m_exl, m_ie}, data);
        read_cp0(CP0_CAUSE, data);
        check("cause", {m_bd, 15'h0, m_ip, 1'b0, m_code, 2'b00}, data);
        read_cp0(CP0_EPC, data);
        check("epc", m_epc, data);
        if (m_bv_known) begin
            read_cp0(CP0_BADVADDR, data);
            check("badvaddr", m_badvaddr, data);
        end
        read_cp0(CP0_ENTRYHI, data);
        check("entryhi", {m_vpn2, 5'h0, m_asid}, data);
    endtask

    // Offers one instruction, checks the redirect, then the CP0 registers.
    // With shadow set a second instruction arrives in the flush cycle.
    task automatic commit(input exc_flags_t flags, input logic [31:0] pc,
                          input logic [31:0] badv, input logic ds,
                          input logic refetch, input logic shadow);
        int          rank;
        logic [8:0]  info;
        logic        int_taken;
        logic        entry;
        logic        is_eret;
        logic        exp_redirect;
        logic [31:0] exp_pc;
        logic [31:0] addr;
        exc_flags_t  other;

        rank = 15;
        for (int r = 14; r >= 0; r--) begin
            if (|(flags & rank_mask(r))) begin
                rank = r;
            end
        end
        info         = 9'h0;
        int_taken    = m_ie & ~m_exl & (|(m_ip & m_im));
        entry        = 1'b0;
        is_eret      = 1'b0;
        exp_redirect = 1'b1;
        exp_pc       = EXC_VECTOR;
        if (refetch) begin
            exp_pc = pc;
        end else if (int_taken) begin
            entry = 1'b1;
            info  = {INT, 4'b0000};
        end else if (rank == 7) begin
            is_eret = 1'b1;
            exp_pc  = m_epc;
        end else if (rank < 15) begin
            entry = 1'b1;
            info  = RANK_INFO[rank];
            if (info[0]) begin
                exp_pc = REFILL_VECTOR;
            end
        end else begin
            exp_redirect = 1'b0;
        end

        @(posedge clk);
        in_valid      <= 1'b1;
        in_refetch    <= refetch;
        in_delay_slot <= ds;
        in_pc         <= pc;
        in_badvaddr   <= badv;
        in_flags      <= flags;
        @(posedge clk);
        if (shadow) begin
            other          = '0;
            other.overflow = 1'b1;
            in_pc    <= pc + 32'd4;
            in_flags <= other;
        end else begin
            in_valid <= 1'b0;
        end
        @(negedge clk);
        check("redirect_valid", 32'(exp_redirect), 32'(redirect_valid));
        check("flush", 32'(exp_redirect), 32'(flush));
        if (exp_redirect) begin
            check("redirect_pc", exp_pc, redirect_pc);
        end
        if (shadow) begin
            @(posedge clk);
            in_valid <= 1'b0;
            @(negedge clk);
            check("redirect_valid", 32'd0, 32'(redirect_valid));
        end

        if (entry) begin
            m_exl  = 1'b1;
            m_bd   = ds;
            m_code = info[8:4];
            m_epc  = ds ? pc - 32'd4 : pc;
            addr   = (info[3:2] == 2'd1) ? pc : badv;
            if (info[3:2] != 2'd0) begin
                m_badvaddr = addr;
                m_bv_known = 1'b1;
            end
            if (info[1]) begin
                m_vpn2 = addr[31:13];
            end
        end else if (is_eret) begin
            m_exl = 1'b0;
        end
        check_regs();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        logic [31:0] data;
        logic [31:0] r1;
        logic [31:0] r2;
        exc_flags_t  flags;
        int unsigned prop_fails;

        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_refetch    = 1'b0;
        in_delay_slot = 1'b0;
        in_pc         = 32'h0;
        in_badvaddr   = 32'h0;
        in_flags      = '0;
        hw_int        = 6'h0;
        cp0_wen       = 1'b0;
        cp0_addr      = 5'h0;
        cp0_wdata     = 32'h0;
        m_ie          = 1'b0;
        m_exl         = 1'b0;
        m_im          = 8'h0;
        m_ip          = 8'h0;
        m_bd          = 1'b0;
        m_code        = 5'd0;
        m_epc         = 32'h0;
        m_badvaddr    = 32'h0;
        m_bv_known    = 1'b0;
        m_vpn2        = 19'h0;
        m_asid        = 8'h0;
        test_errors   = 0;
        total_errors  = 0;
        tests_run     = 0;
        tests_failed  = 0;

        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check("redirect_valid", 32'd0, 32'(redirect_valid));
        check("flush", 32'd0, 32'(flush));
        read_cp0(CP0_STATUS, data);
        check("status", 32'd0, data);
        write_cp0(CP0_EPC, 32'h0000_0000);
        write_cp0(CP0_ENTRYHI, 32'h0000_205a);
        commit('0, 32'h0040_0000, 32'h0, 1'b0, 1'b0, 1'b0);
        end_test("reset");

        for (int r = 0; r < 15; r++) begin
            if (r == 7) begin
                continue;
            end
            for (int d = 0; d < 2; d++) begin
                commit(rank_mask(r), 32'h0040_0000 + 32'(r) * 32'h100,
                       32'h1234_5000 ^ (32'(r) << 13), d[0], 1'b0, 1'b0);
            end
        end
        end_test("single_flags");

        for (int i = 0; i < 40; i++) begin
            r1    = $random(seed);
            r2    = $random(seed);
            flags = exc_flags_t'(r1[14:0] & r2[14:0]);
            if (flags == '0) begin
                flags.modify = 1'b1;
            end
            r1 = $random(seed);
            r2 = $random(seed);
            commit(flags, {r1[31:2], 2'b00}, r2, r1[0], 1'b0, 1'b0);
        end
        end_test("random_flags");

        flags         = '0;
        flags.syscall = 1'b1;
        commit(flags, 32'h0040_8000, 32'h0, 1'b0, 1'b0, 1'b1);
        end_test("flush_drop");

        write_cp0(CP0_EPC, 32'h8000_1230);
        write_cp0(CP0_STATUS, 32'h0000_0002);
        flags      = '0;
        flags.eret = 1'b1;
        commit(flags, 32'h8000_0180, 32'h0, 1'b0, 1'b0, 1'b0);
        end_test("eret");

        flags         = '0;
        flags.syscall = 1'b1;
        commit(flags, 32'h0040_9000, 32'h0, 1'b0, 1'b1, 1'b0);
        end_test("refetch");

        // Line 2 maps to Cause.IP[4] and Status.IM[4].
        @(posedge clk);
        hw_int <= 6'b000100;
        m_ip = 8'h10;
        write_cp0(CP0_STATUS, 32'h0000_1001);
        commit('0, 32'h0040_a000, 32'h0, 1'b0, 1'b0, 1'b0);
        commit('0, 32'h0040_a100, 32'h0, 1'b0, 1'b0, 1'b0);
        write_cp0(CP0_STATUS, 32'h0000_0001);
        commit('0, 32'h0040_a200, 32'h0, 1'b0, 1'b0, 1'b0);
        @(posedge clk);
        hw_int <= 6'h0;
        end_test("interrupt");

        prop_fails = i_exception_unit.i_properties.fail_count;
        $display("Summary: %0d tests, %0d failed, %0d check errors, %0d property failures",
                 tests_run, tests_failed, total_errors, prop_fails);
        if (tests_failed == 0 && total_errors == 0 && prop_fails == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * MAX_TEST_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* flist.f */
verilog/exc_pkg.sv
verilog/cp0_write_if.sv
verilog/commit_latch.sv
verilog/exception_ctrl.sv
verilog/cp0_regs.sv
verilog/exception_unit.sv
bench/exception_unit_properties.sv
bench/tb_exception_unit.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_exception_unit -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_exception_unit +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1
